// File: design/adc_capture_pkg.sv
package adc_capture_pkg;

    localparam int SAMPLE_W         = 12;
    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;
    localparam int BYTE_W           = 8;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;      // earliest sample in the top bits
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [14:0]         presample_t;
    typedef logic [12:0]         downsample_t; // samples skipped between kept ones
    typedef logic [31:0]         sample_count_t;

    typedef struct packed {
        presample_t    presamples;
        downsample_t   downsample;
        sample_count_t max_samples;
        logic          low_res;      // 8 bits per sample on readout
        logic          low_res_lsb;  // low byte instead of high byte
    } capture_cfg_t;

    typedef struct packed {
        logic downsample_err;
        logic presamp_err;
        logic sample_ovf;
        logic word_ovf;
        logic read_underflow;
    } err_stat_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_e;

endpackage

// File: design/adc_capture_top.sv
module adc_capture_top #(
    parameter int SAMPLE_DEPTH = 64,
    parameter int WORD_DEPTH   = 512
) (
    input  logic                           adc_sampleclk,
    input  logic                           fifo_rst,
    input  adc_capture_pkg::sample_t       adc_data_i,
    input  logic                           arm_i,
    input  logic                           capture_go_i,
    input  adc_capture_pkg::presample_t    presample_i,
    input  adc_capture_pkg::downsample_t   downsample_i,
    input  adc_capture_pkg::sample_count_t max_samples_i,
    input  logic                           low_res_i,
    input  logic                           low_res_lsb_i,
    input  logic                           read_en_i,
    input  logic                           clear_errors_i,
    output logic                           capture_stop_o,
    output logic                           read_empty_o,
    output adc_capture_pkg::byte_t         read_data_o,
    output logic                           error_flag_o,
    output adc_capture_pkg::err_stat_t     error_stat_o
);

    import adc_capture_pkg::*;

    capture_cfg_t cfg;
    logic         arm_pulse;
    logic         cfg_err;
    logic         presamp_err;
    logic         capture_active;
    logic         sample_wr;
    logic         sample_drain;
    logic         sample_rd;
    sample_t      sample_dout;
    logic         sample_empty;
    logic         sample_ovf;
    word_t        word_din;
    logic         word_wr;
    logic         word_rd;
    word_t        word_dout;
    logic         word_full;
    logic         word_ovf;
    logic         read_underflow;

    capture_config_regs capture_config_regs_i (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .arm_i            (arm_i),
        .presample_i      (presample_i),
        .downsample_i     (downsample_i),
        .max_samples_i    (max_samples_i),
        .low_res_i        (low_res_i),
        .low_res_lsb_i    (low_res_lsb_i),
        .cfg_o            (cfg),
        .arm_pulse_o      (arm_pulse),
        .downsample_err_o (cfg_err)
    );

    capture_fsm capture_fsm_i (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .cfg_i            (cfg),
        .arm_pulse_i      (arm_pulse),
        .capture_go_i     (capture_go_i),
        .sample_empty_i   (sample_empty),
        .sample_wr_o      (sample_wr),
        .sample_drain_o   (sample_drain),
        .capture_active_o (capture_active),
        .capture_stop_o   (capture_stop_o),
        .presamp_err_o    (presamp_err)
    );

    sample_fifo #(
        .WIDTH (SAMPLE_W),
        .DEPTH (SAMPLE_DEPTH)
    ) sample_buf_i (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .din_i         (adc_data_i),
        .wr_i          (sample_wr),
        .rd_i          (sample_rd | sample_drain),  // drain and packer never overlap
        .dout_o        (sample_dout),
        .empty_o       (sample_empty),
        .full_o        (),
        .overflow_o    (sample_ovf),
        .underflow_o   ()
    );

    sample_packer sample_packer_i (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .capture_active_i (capture_active),
        .sample_i         (sample_dout),
        .sample_empty_i   (sample_empty),
        .word_full_i      (word_full),
        .sample_rd_o      (sample_rd),
        .word_o           (word_din),
        .word_wr_o        (word_wr)
    );

    sample_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (WORD_DEPTH)
    ) word_buf_i (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .din_i         (word_din),
        .wr_i          (word_wr),
        .rd_i          (word_rd),
        .dout_o        (word_dout),
        .empty_o       (read_empty_o),
        .full_o        (word_full),
        .overflow_o    (word_ovf),
        .underflow_o   ()
    );

    byte_unpacker byte_unpacker_i (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .cfg_i         (cfg),
        .read_en_i     (read_en_i),
        .word_i        (word_dout),
        .word_empty_i  (read_empty_o),
        .word_rd_o     (word_rd),
        .read_data_o   (read_data_o),
        .underflow_o   (read_underflow)
    );

    error_status error_status_i (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .clear_errors_i   (clear_errors_i),
        .arm_pulse_i      (arm_pulse),
        .downsample_err_i (cfg_err),
        .presamp_err_i    (presamp_err),
        .sample_ovf_i     (sample_ovf),
        .word_ovf_i       (word_ovf),
        .read_underflow_i (read_underflow),
        .error_stat_o     (error_stat_o),
        .error_flag_o     (error_flag_o)
    );

endmodule

// File: design/byte_unpacker.sv
module byte_unpacker (
    input  logic                          adc_sampleclk,
    input  logic                          fifo_rst,
    input  adc_capture_pkg::capture_cfg_t cfg_i,
    input  logic                          read_en_i,
    input  adc_capture_pkg::word_t        word_i,
    input  logic                          word_empty_i,
    output logic                          word_rd_o,
    output adc_capture_pkg::byte_t        read_data_o,
    output logic                          underflow_o
);

    import adc_capture_pkg::*;

    logic [3:0] idx;        // byte position in the word, or in the word pair
    logic [3:0] last_idx;
    logic [3:0] nibble;     // low bits of the first word of a pair
    logic       have;       // word_i holds a word with unread bytes
    logic       rd_ok;
    logic       word_done;
    sample_t    lr_sample;
    byte_t      next_byte;

    assign last_idx  = cfg_i.low_res ? 4'd2 : 4'd8;
    assign rd_ok     = read_en_i && have;
    assign word_done = rd_ok && (idx == last_idx || (!cfg_i.low_res && idx == 4'd3));
    assign word_rd_o = !word_empty_i && (!have || word_done);

    always_comb begin
        case (idx)
            4'd0:    lr_sample = word_i[2*SAMPLE_W +: SAMPLE_W];
            4'd1:    lr_sample = word_i[SAMPLE_W +: SAMPLE_W];
            default: lr_sample = word_i[0 +: SAMPLE_W];
        endcase
    end

    always_comb begin
        if (cfg_i.low_res) begin
            next_byte = cfg_i.low_res_lsb ? lr_sample[BYTE_W-1:0]
                                          : lr_sample[SAMPLE_W-1 -: BYTE_W];
        end else begin
            case (idx)  // nine bytes over two words, MSB first
                4'd0:    next_byte = word_i[35:28];
                4'd1:    next_byte = word_i[27:20];
                4'd2:    next_byte = word_i[19:12];
                4'd3:    next_byte = word_i[11:4];
                4'd4:    next_byte = {nibble, word_i[35:32]};
                4'd5:    next_byte = word_i[31:24];
                4'd6:    next_byte = word_i[23:16];
                4'd7:    next_byte = word_i[15:8];
                default: next_byte = word_i[7:0];
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            idx         <= '0;
            have        <= 1'b0;
            underflow_o <= 1'b0;
            read_data_o <= '0;
        end else begin
            underflow_o <= read_en_i && !have;
            if (word_rd_o)
                have <= 1'b1;
            else if (word_done)
                have <= 1'b0;
            if (read_en_i)
                read_data_o <= have ? next_byte : '0;  // zero when nothing to read
            if (rd_ok)
                idx <= (idx == last_idx) ? '0 : idx + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (rd_ok && !cfg_i.low_res && idx == 4'd3)
            nibble <= word_i[3:0];
    end

endmodule

// File: design/capture_config_regs.sv
module capture_config_regs (
    input  logic                           adc_sampleclk,
    input  logic                           fifo_rst,
    input  logic                           arm_i,
    input  adc_capture_pkg::presample_t    presample_i,
    input  adc_capture_pkg::downsample_t   downsample_i,
    input  adc_capture_pkg::sample_count_t max_samples_i,
    input  logic                           low_res_i,
    input  logic                           low_res_lsb_i,
    output adc_capture_pkg::capture_cfg_t  cfg_o,
    output logic                           arm_pulse_o,
    output logic                           downsample_err_o
);

    logic arm_r;
    logic arm_edge;

    assign arm_edge = arm_i && !arm_r;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            arm_r            <= 1'b0;
            arm_pulse_o      <= 1'b0;
            downsample_err_o <= 1'b0;
            cfg_o            <= '0;
        end else begin
            arm_r            <= arm_i;
            arm_pulse_o      <= arm_edge;  // lines up with the new cfg_o
            // downsampling cannot be combined with presamples
            downsample_err_o <= arm_edge && (downsample_i != '0) && (presample_i != '0);
            if (arm_edge) begin
                cfg_o.presamples  <= presample_i;
                cfg_o.downsample  <= downsample_i;
                cfg_o.max_samples <= max_samples_i;
                cfg_o.low_res     <= low_res_i;
                cfg_o.low_res_lsb <= low_res_lsb_i;
            end
        end
    end

endmodule

// File: design/capture_fsm.sv
module capture_fsm (
    input  logic                          adc_sampleclk,
    input  logic                          fifo_rst,
    input  adc_capture_pkg::capture_cfg_t cfg_i,
    input  logic                          arm_pulse_i,
    input  logic                          capture_go_i,
    input  logic                          sample_empty_i,
    output logic                          sample_wr_o,
    output logic                          sample_drain_o,
    output logic                          capture_active_o,
    output logic                          capture_stop_o,
    output logic                          presamp_err_o
);

    import adc_capture_pkg::*;

    capture_state_e state;
    logic           armed;       // armed without presamples, waiting for go
    downsample_t    ds_cnt;
    presample_t     pre_cnt;     // samples held in the FIFO before trigger
    sample_count_t  sample_cnt;
    sample_count_t  cnt_base;
    sample_count_t  cnt_next;
    logic [1:0]     phase;       // kept samples mod 3
    logic           waiting;
    logic           trig;
    logic           sampling;
    logic           last_wr;

    assign waiting  = (state == IDLE && armed) || state == PRESAMP_FILLING ||
                      state == PRESAMP_FULL;
    assign trig     = waiting && capture_go_i;
    assign sampling = trig || state == PRESAMP_FILLING || state == PRESAMP_FULL ||
                      state == TRIGGERED;

    // the sample on adc_data_i is written in the same cycle as go
    assign sample_wr_o      = sampling && (ds_cnt == '0);
    assign sample_drain_o   = sample_wr_o && state == PRESAMP_FULL && !trig;
    assign capture_active_o = (state == TRIGGERED) || (state == DONE);

    // presamples already in the FIFO count towards max_samples
    assign cnt_base = (state == TRIGGERED) ? sample_cnt : sample_count_t'(pre_cnt);
    assign cnt_next = cnt_base + 1'b1;
    assign last_wr  = (trig || state == TRIGGERED) && sample_wr_o &&
                      (cnt_next >= cfg_i.max_samples) && (phase == 2'd2);

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            state          <= IDLE;
            armed          <= 1'b0;
            ds_cnt         <= '0;
            pre_cnt        <= '0;
            sample_cnt     <= '0;
            phase          <= '0;
            capture_stop_o <= 1'b0;
            presamp_err_o  <= 1'b0;
        end else if (arm_pulse_i) begin
            state          <= (cfg_i.presamples != '0) ? PRESAMP_FILLING : IDLE;
            armed          <= (cfg_i.presamples == '0);
            ds_cnt         <= '0;
            pre_cnt        <= '0;
            sample_cnt     <= '0;
            phase          <= '0;
            capture_stop_o <= 1'b0;
            presamp_err_o  <= 1'b0;
        end else begin
            presamp_err_o <= trig && state == PRESAMP_FILLING;  // trigger came too early

            if (!sampling || ds_cnt >= cfg_i.downsample)
                ds_cnt <= '0;
            else
                ds_cnt <= ds_cnt + 1'b1;

            if (sample_wr_o && !sample_drain_o)
                phase <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;

            if (sample_wr_o && (trig || state == TRIGGERED))
                sample_cnt <= cnt_next;
            else if (trig)
                sample_cnt <= sample_count_t'(pre_cnt);

            if (last_wr)
                capture_stop_o <= 1'b1;  // held until the next arm

            case (state)
                PRESAMP_FILLING: begin
                    if (sample_wr_o)
                        pre_cnt <= pre_cnt + 1'b1;
                    if (sample_wr_o && (pre_cnt + 1'b1 == cfg_i.presamples))
                        state <= PRESAMP_FULL;
                end
                TRIGGERED: if (last_wr) state <= DONE;
                DONE:      if (sample_empty_i) state <= IDLE;  // packer has taken all
                default:   ;
            endcase

            if (trig) begin
                armed <= 1'b0;
                state <= last_wr ? DONE : TRIGGERED;
            end
        end
    end

endmodule

// File: design/error_status.sv
module error_status (
    input  logic                       adc_sampleclk,
    input  logic                       fifo_rst,
    input  logic                       clear_errors_i,
    input  logic                       arm_pulse_i,
    input  logic                       downsample_err_i,
    input  logic                       presamp_err_i,
    input  logic                       sample_ovf_i,
    input  logic                       word_ovf_i,
    input  logic                       read_underflow_i,
    output adc_capture_pkg::err_stat_t error_stat_o,
    output logic                       error_flag_o
);

    import adc_capture_pkg::*;

    err_stat_t hits;

    always_comb begin
        hits.downsample_err = downsample_err_i;
        hits.presamp_err    = presamp_err_i;
        hits.sample_ovf     = sample_ovf_i;
        hits.word_ovf       = word_ovf_i;
        hits.read_underflow = read_underflow_i;
    end

    assign error_flag_o = |error_stat_o;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst)
            error_stat_o <= '0;
        else if (clear_errors_i || arm_pulse_i)
            error_stat_o <= hits;  // a pulse in the clearing cycle still counts
        else
            error_stat_o <= error_stat_o | hits;
    end

endmodule

// File: design/sample_fifo.sv
module sample_fifo #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 64
) (
    input  logic             adc_sampleclk,
    input  logic             fifo_rst,
    input  logic [WIDTH-1:0] din_i,
    input  logic             wr_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             wr_ok;
    logic             rd_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == (AW+1)'(DEPTH));
    assign rd_ok   = rd_i && !empty_o;
    assign wr_ok   = wr_i && (!full_o || rd_ok);  // a read in the same cycle frees a slot

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (wr_ok)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (wr_ok && !rd_ok)
                count <= count + 1'b1;
            else if (rd_ok && !wr_ok)
                count <= count - 1'b1;
            overflow_o  <= wr_i && !wr_ok;  // dropped write
            underflow_o <= rd_i && !rd_ok;  // dropped read
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok)
            mem[wr_ptr] <= din_i;
        if (rd_ok)
            dout_o <= mem[rd_ptr];  // data valid the cycle after rd_i
    end

endmodule

// File: design/sample_packer.sv
module sample_packer (
    input  logic                     adc_sampleclk,
    input  logic                     fifo_rst,
    input  logic                     capture_active_i,
    input  adc_capture_pkg::sample_t sample_i,
    input  logic                     sample_empty_i,
    input  logic                     word_full_i,
    output logic                     sample_rd_o,
    output adc_capture_pkg::word_t   word_o,
    output logic                     word_wr_o
);

    import adc_capture_pkg::*;

    sample_t [SAMPLES_PER_WORD-2:0] held;  // earlier samples of the word
    logic [1:0]                     slot;
    logic                           rd_q;  // sample_i valid this cycle

    assign sample_rd_o = capture_active_i && !sample_empty_i && !word_full_i;

    // third sample goes straight into the word, so full is seen early enough
    assign word_wr_o = rd_q && (slot == 2'(SAMPLES_PER_WORD-1));
    assign word_o    = {held, sample_i};

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            rd_q <= 1'b0;
            slot <= '0;
        end else begin
            rd_q <= sample_rd_o;
            if (rd_q)
                slot <= (slot == 2'(SAMPLES_PER_WORD-1)) ? '0 : slot + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (rd_q)
            held <= {held[SAMPLES_PER_WORD-3:0], sample_i};
    end

endmodule

// File: dv/adc_capture_tb.sv
module adc_capture_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import adc_capture_pkg::*;

    localparam int TIMEOUT = 2000;  // cycles allowed per wait

    logic          adc_sampleclk;
    logic          fifo_rst;
    sample_t       adc_data_i;
    logic          arm_i;
    logic          capture_go_i;
    presample_t    presample_i;
    downsample_t   downsample_i;
    sample_count_t max_samples_i;
    logic          low_res_i;
    logic          low_res_lsb_i;
    logic          read_en_i;
    logic          clear_errors_i;
    logic          capture_stop_o;
    logic          read_empty_o;
    byte_t         read_data_o;
    logic          error_flag_o;
    err_stat_t     error_stat_o;

    sample_t       drive_log[$];      // every value put on adc_data_i, in order
    byte_t         exp_q[$];
    byte_t         exp_byte;
    logic          rd_seen = 1'b0;    // DUT took a read at the last edge
    logic [15:0]   lfsr_state = 16'd15;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            base;

    adc_capture_top #(
        .SAMPLE_DEPTH (64),
        .WORD_DEPTH   (512)
    ) adc_capture_top_i (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .adc_data_i     (adc_data_i),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .presample_i    (presample_i),
        .downsample_i   (downsample_i),
        .max_samples_i  (max_samples_i),
        .low_res_i      (low_res_i),
        .low_res_lsb_i  (low_res_lsb_i),
        .read_en_i      (read_en_i),
        .clear_errors_i (clear_errors_i),
        .capture_stop_o (capture_stop_o),
        .read_empty_o   (read_empty_o),
        .read_data_o    (read_data_o),
        .error_flag_o   (error_flag_o),
        .error_stat_o   (error_stat_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #4 adc_sampleclk = ~adc_sampleclk;
    end

    // free-running ramp on the ADC input
    always @(posedge adc_sampleclk) begin
        adc_data_i <= adc_data_i + 1'b1;
        drive_log.push_back(sample_t'(adc_data_i + 1'b1));
    end

    always @(posedge adc_sampleclk)
        rd_seen <= read_en_i;

    // byte checker, read_data_o is settled by the falling edge
    always @(negedge adc_sampleclk) begin
        if (rd_seen) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: byte read although none was expected", $time);
                errors++;
            end else begin
                exp_byte = exp_q.pop_front();
                if (read_data_o !== exp_byte) begin
                    $display("ERROR %0t ns: read_data_o expected %h got %h",
                             $time, exp_byte, read_data_o);
                    errors++;
                end
            end
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11 + 1
        return {s[14:0], fb};
    endfunction

    function automatic int round_up3(input int n);
        return ((n + 2) / 3) * 3;
    endfunction

    // expected host bytes for one capture, queued in read order
    function automatic int build_expected(input int trig_idx, input int pre, input int ds,
                                          input int max_s, input bit lr, input bit lsb);
        sample_t       smp[$];
        logic [71:0]   pair;
        int            total;
        int            first;
        total = round_up3(max_s);  // presamples count towards the total
        first = trig_idx - pre;
        for (int k = 0; k < total; k++)
            smp.push_back(drive_log[first + k * (ds + 1)]);
        if (lr) begin
            foreach (smp[k])
                exp_q.push_back(lsb ? smp[k][7:0] : smp[k][11:4]);
            return total;
        end
        for (int w = 0; w + 6 <= total; w += 6) begin
            pair = {smp[w], smp[w+1], smp[w+2], smp[w+3], smp[w+4], smp[w+5]};
            for (int b = 8; b >= 0; b--)
                exp_q.push_back(pair[b*8 +: 8]);  // MSB first
        end
        return (total / 6) * 9;
    endfunction

    task automatic abort_run(input string why);
        $display("%s, stopping the run", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic apply_reset();
        @(posedge adc_sampleclk);
        fifo_rst <= 1'b1;
        repeat (4) @(posedge adc_sampleclk);
        fifo_rst <= 1'b0;
    endtask

    task automatic arm_capture(input int pre, input int ds, input int max_s,
                               input bit lr, input bit lsb);
        @(posedge adc_sampleclk);
        presample_i   <= presample_t'(pre);
        downsample_i  <= downsample_t'(ds);
        max_samples_i <= sample_count_t'(max_s);
        low_res_i     <= lr;
        low_res_lsb_i <= lsb;
        arm_i         <= 1'b1;
        @(posedge adc_sampleclk);
        arm_i <= 1'b0;
    endtask

    // one-cycle go pulse, idx is the log position of the sample driven with it
    task automatic fire_trigger(input int delay, output int idx);
        repeat (delay) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk);
        idx = drive_log.size();
        @(posedge adc_sampleclk);
        capture_go_i <= 1'b1;
        @(posedge adc_sampleclk);
        capture_go_i <= 1'b0;
    endtask

    task automatic await_readout();
        int n;
        n = 0;
        @(negedge adc_sampleclk);
        while (capture_stop_o !== 1'b1 && n < TIMEOUT) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (capture_stop_o !== 1'b1)
            abort_run("capture_stop_o never rose");
        n = 0;
        while (read_empty_o !== 1'b0 && n < TIMEOUT) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (read_empty_o !== 1'b0)
            abort_run("no word reached the read side");
    endtask

    task automatic wait_flag(input logic level);
        int n;
        n = 0;
        @(negedge adc_sampleclk);
        while (error_flag_o !== level && n < TIMEOUT) begin
            @(negedge adc_sampleclk);
            n++;
        end
        if (error_flag_o !== level)
            abort_run("error_flag_o did not reach the expected level");
    endtask

    task automatic drain_compare();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge adc_sampleclk);
            n++;
        end
        if (exp_q.size() != 0)
            abort_run("expected bytes were never read back");
        @(negedge adc_sampleclk);
    endtask

    // strobes read_en_i with a random gap of 1 to 4 cycles before each read
    task automatic read_bytes(input int count);
        logic [1:0] bits;
        for (int i = 0; i < count; i++) begin
            for (int b = 0; b < 2; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                bits = {bits[0], lfsr_state[0]};
            end
            repeat (1 + bits) @(posedge adc_sampleclk);
            read_en_i <= 1'b1;
            @(posedge adc_sampleclk);
            read_en_i <= 1'b0;
        end
    endtask

    task automatic capture_and_read(input int pre, input int ds, input int max_s,
                                    input bit lr, input bit lsb, input int delay);
        int idx;
        int count;
        arm_capture(pre, ds, max_s, lr, lsb);
        fire_trigger(delay, idx);
        await_readout();
        count = build_expected(idx, pre, ds, max_s, lr, lsb);
        read_bytes(count);
        drain_compare();
    endtask

    task automatic clear_errors();
        @(posedge adc_sampleclk);
        clear_errors_i <= 1'b1;
        @(posedge adc_sampleclk);
        clear_errors_i <= 1'b0;
        wait_flag(1'b0);
        if (error_stat_o !== '0) begin
            $display("ERROR %0t ns: error_stat_o expected 00 got %h", $time, error_stat_o);
            errors++;
        end
    endtask

    task automatic expect_no_errors();
        if (error_flag_o !== 1'b0) begin
            $display("ERROR %0t ns: error_flag_o expected 0 got %b", $time, error_flag_o);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    initial begin
        fifo_rst       = 1'b1;
        adc_data_i     = '0;
        arm_i          = 1'b0;
        capture_go_i   = 1'b0;
        presample_i    = '0;
        downsample_i   = '0;
        max_samples_i  = '0;
        low_res_i      = 1'b0;
        low_res_lsb_i  = 1'b0;
        read_en_i      = 1'b0;
        clear_errors_i = 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        fifo_rst <= 1'b0;

        base = errors;
        @(negedge adc_sampleclk);
        if (capture_stop_o !== 1'b0) begin
            $display("ERROR %0t ns: capture_stop_o expected 0 got %b", $time, capture_stop_o);
            errors++;
        end
        if (read_empty_o !== 1'b1) begin
            $display("ERROR %0t ns: read_empty_o expected 1 got %b", $time, read_empty_o);
            errors++;
        end
        expect_no_errors();
        end_test("values after reset", base);

        base = errors;
        capture_and_read(0, 0, 6, 1'b0, 1'b0, 1);
        expect_no_errors();
        end_test("12-bit readout of six samples", base);

        base = errors;
        capture_and_read(0, 0, 6, 1'b1, 1'b0, 2);
        expect_no_errors();
        end_test("low-res readout, upper byte", base);

        base = errors;
        capture_and_read(0, 0, 6, 1'b1, 1'b1, 3);
        expect_no_errors();
        end_test("low-res readout, lower byte", base);

        base = errors;
        capture_and_read(5, 0, 12, 1'b0, 1'b0, 15);  // P+10 cycles after arm
        expect_no_errors();
        end_test("five presamples before trigger", base);

        base = errors;
        capture_and_read(0, 2, 7, 1'b1, 1'b1, 1);
        if (read_empty_o !== 1'b1) begin
            $display("ERROR %0t ns: read_empty_o expected 1 got %b", $time, read_empty_o);
            errors++;
        end
        expect_no_errors();
        exp_q.push_back(8'h00);  // a tenth sample would show up here
        read_bytes(1);
        drain_compare();
        wait_flag(1'b1);
        if (error_stat_o.read_underflow !== 1'b1) begin
            $display("ERROR %0t ns: error_stat_o.read_underflow expected 1 got %b",
                     $time, error_stat_o.read_underflow);
            errors++;
        end
        clear_errors();
        end_test("downsample by three, nine samples", base);

        base = errors;
        arm_capture(4, 2, 6, 1'b0, 1'b0);
        wait_flag(1'b1);
        if (error_stat_o.downsample_err !== 1'b1) begin
            $display("ERROR %0t ns: error_stat_o.downsample_err expected 1 got %b",
                     $time, error_stat_o.downsample_err);
            errors++;
        end
        clear_errors();
        end_test("downsample with presamples flagged", base);

        base = errors;
        arm_capture(20, 0, 6, 1'b1, 1'b0);
        fire_trigger(1, base);
        base = errors;
        wait_flag(1'b1);
        if (error_stat_o.presamp_err !== 1'b1) begin
            $display("ERROR %0t ns: error_stat_o.presamp_err expected 1 got %b",
                     $time, error_stat_o.presamp_err);
            errors++;
        end
        clear_errors();
        end_test("trigger before presamples full", base);
        apply_reset();  // flush the partial capture

        base = errors;
        capture_and_read(0, 0, 6, 1'b1, 1'b0, 1);
        expect_no_errors();
        exp_q.push_back(8'h00);  // nothing left to read
        read_bytes(1);
        drain_compare();
        wait_flag(1'b1);
        if (error_stat_o.read_underflow !== 1'b1) begin
            $display("ERROR %0t ns: error_stat_o.read_underflow expected 1 got %b",
                     $time, error_stat_o.read_underflow);
            errors++;
        end
        clear_errors();
        end_test("read past the end of data", base);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: sources.f
design/adc_capture_pkg.sv
design/sample_fifo.sv
design/capture_config_regs.sv
design/capture_fsm.sv
design/sample_packer.sv
design/byte_unpacker.sv
design/error_status.sv
design/adc_capture_top.sv
dv/adc_capture_tb.sv
